// File: Makefile
# Verilator flow for the memory stage testbench.

VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL TESTS PASSED
VFLAGS    ?= --timing
SOURCES   := $(wildcard hw/*.sv) $(wildcard tests/*.sv)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only if the log holds the pass line.
sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/core_pkg.sv
`default_nettype none

package core_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [11:0] csr_addr_t;

	// Access size encodings for mem_flags.size.
	localparam logic [1:0] SIZE_BYTE = 2'd0;
	localparam logic [1:0] SIZE_HALF = 2'd1;
	localparam logic [1:0] SIZE_WORD = 2'd2;

	typedef struct packed {
		logic       read;
		logic       write;
		logic [1:0] size;
		logic       zero_ext; // Zero extend on load.
	} mem_flags_t;

	typedef enum logic [2:0] {
		CSR_NONE = 3'd0,
		CSR_RW   = 3'd1,
		CSR_RS   = 3'd2,
		CSR_RC   = 3'd3
	} csr_op_t;

	localparam csr_addr_t CSR_MSCRATCH = 12'h340;
	localparam csr_addr_t CSR_MEPC     = 12'h341;
	localparam csr_addr_t CSR_MCAUSE   = 12'h342;
	localparam csr_addr_t CSR_MTVAL    = 12'h343;
	localparam csr_addr_t CSR_MHARTID  = 12'hF14; // Read only, reads zero.

	typedef enum logic [4:0] {
		EXC_INSTR_MISALIGN = 5'd0,
		EXC_ILLEGAL        = 5'd2,
		EXC_BREAKPOINT     = 5'd3,
		EXC_LOAD_MISALIGN  = 5'd4,
		EXC_STORE_MISALIGN = 5'd6,
		EXC_ECALL          = 5'd11
	} exc_cause_t;

	// Jump opcodes, to tell a bad jump target from a bad branch target.
	localparam logic [6:0] OPC_JAL  = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;

endpackage

`default_nettype wire

// File: hw/csr_file.sv
`timescale 1ns/10ps
`default_nettype none

module csr_file (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 exc_taken,
	input  core_pkg::exc_cause_t exc_cause,
	input  core_pkg::xlen_t      exc_tval,
	exmem_if.consumer            stage,
	output core_pkg::xlen_t      csr_rdata,
	output logic                 csr_illegal
);
	import core_pkg::*;

	xlen_t mscratch;
	xlen_t mepc;
	xlen_t mcause;
	xlen_t mtval;
	logic  addr_known;
	logic  op_writes;
	logic  write_en;
	xlen_t wval;

	always_comb begin
		addr_known = 1'b1;
		case (stage.csr_addr)
			CSR_MSCRATCH: csr_rdata = mscratch;
			CSR_MEPC:     csr_rdata = mepc;
			CSR_MCAUSE:   csr_rdata = mcause;
			CSR_MTVAL:    csr_rdata = mtval;
			CSR_MHARTID:  csr_rdata = '0; // Single hart.
			default: begin
				csr_rdata  = '0;
				addr_known = 1'b0;
			end
		endcase
	end

	// Set or clear with a zero immediate only reads.
	assign op_writes = !((stage.csr_op == CSR_RS || stage.csr_op == CSR_RC) &&
		stage.csr_imm_op && stage.csr_data == '0);

	assign csr_illegal = (stage.csr_op != CSR_NONE) &&
		(!addr_known || (stage.csr_addr == CSR_MHARTID && op_writes));

	always_comb begin
		case (stage.csr_op)
			CSR_RW:  wval = stage.csr_data;
			CSR_RS:  wval = csr_rdata | stage.csr_data;
			CSR_RC:  wval = csr_rdata & ~stage.csr_data;
			default: wval = csr_rdata;
		endcase
	end

	assign write_en = (stage.csr_op == CSR_RW || stage.csr_op == CSR_RS ||
		stage.csr_op == CSR_RC) && op_writes;

	// Trap capture takes over any CSR write.
	always_ff @(posedge clk) begin
		if (rst) begin
			mscratch <= '0;
			mepc     <= '0;
			mcause   <= '0;
			mtval    <= '0;
		end else if (exc_taken) begin
			mepc   <= stage.pc;
			mcause <= {27'b0, exc_cause};
			mtval  <= exc_tval;
		end else if (write_en) begin
			case (stage.csr_addr)
				CSR_MSCRATCH: mscratch <= wval;
				CSR_MEPC:     mepc     <= wval;
				CSR_MCAUSE:   mcause   <= wval;
				CSR_MTVAL:    mtval    <= wval;
				default:      ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/exmem_if.sv
`timescale 1ns/10ps
`default_nettype none

interface exmem_if;
	import core_pkg::*;

	xlen_t      pc;
	xlen_t      instruction;
	xlen_t      result;          // ALU result, also the memory address.
	reg_addr_t  waddr;
	logic       we;
	mem_flags_t mem_flags;
	logic       mem_ex_sel;      // Write back takes load data.
	xlen_t      bad_jump_addr;
	xlen_t      bad_branch_addr;
	logic       break_op;
	logic       syscall_op;
	xlen_t      csr_data;        // CSR operand, or store data.
	csr_op_t    csr_op;
	logic       csr_imm_op;
	csr_addr_t  csr_addr;
	logic       exc_addr_if;

	modport producer (
		output pc, instruction, result, waddr, we, mem_flags, mem_ex_sel,
		bad_jump_addr, bad_branch_addr, break_op, syscall_op,
		csr_data, csr_op, csr_imm_op, csr_addr, exc_addr_if
	);

	modport consumer (
		input pc, instruction, result, waddr, we, mem_flags, mem_ex_sel,
		bad_jump_addr, bad_branch_addr, break_op, syscall_op,
		csr_data, csr_op, csr_imm_op, csr_addr, exc_addr_if
	);

endinterface

`default_nettype wire

// File: hw/exmem_reg.sv
`timescale 1ns/10ps
`default_nettype none

module exmem_reg (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 stall,
	input  logic                 flush,
	input  core_pkg::xlen_t      ex_pc,
	input  core_pkg::xlen_t      ex_instruction,
	input  core_pkg::xlen_t      ex_result,
	input  core_pkg::reg_addr_t  ex_waddr,
	input  logic                 ex_we,
	input  core_pkg::mem_flags_t ex_mem_flags,
	input  logic                 ex_mem_ex_sel,
	input  core_pkg::xlen_t      ex_bad_jump_addr,
	input  core_pkg::xlen_t      ex_bad_branch_addr,
	input  logic                 ex_break_op,
	input  logic                 ex_syscall_op,
	input  core_pkg::xlen_t      ex_csr_data,
	input  core_pkg::csr_op_t    ex_csr_op,
	input  logic                 ex_csr_imm_op,
	input  core_pkg::csr_addr_t  ex_csr_addr,
	input  logic                 ex_exc_addr_if,
	exmem_if.producer            out
);
	import core_pkg::*;

	// Flush wins over stall.
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			out.pc              <= '0;
			out.instruction     <= '0;
			out.result          <= '0;
			out.waddr           <= '0;
			out.we              <= 1'b0;
			out.mem_flags       <= '0;
			out.mem_ex_sel      <= 1'b0;
			out.bad_jump_addr   <= '0;
			out.bad_branch_addr <= '0;
			out.break_op        <= 1'b0;
			out.syscall_op      <= 1'b0;
			out.csr_data        <= '0;
			out.csr_op          <= CSR_NONE;
			out.csr_imm_op      <= 1'b0;
			out.csr_addr        <= '0;
			out.exc_addr_if     <= 1'b0;
		end else if (!stall) begin
			out.pc              <= ex_pc;
			out.instruction     <= ex_instruction;
			out.result          <= ex_result;
			out.waddr           <= ex_waddr;
			out.we              <= ex_we;
			out.mem_flags       <= ex_mem_flags;
			out.mem_ex_sel      <= ex_mem_ex_sel;
			out.bad_jump_addr   <= ex_bad_jump_addr;
			out.bad_branch_addr <= ex_bad_branch_addr;
			out.break_op        <= ex_break_op;
			out.syscall_op      <= ex_syscall_op;
			out.csr_data        <= ex_csr_data;
			out.csr_op          <= ex_csr_op;
			out.csr_imm_op      <= ex_csr_imm_op;
			out.csr_addr        <= ex_csr_addr;
			out.exc_addr_if     <= ex_exc_addr_if;
		end
	end

endmodule

`default_nettype wire

// File: hw/mem_access.sv
`timescale 1ns/10ps
`default_nettype none

module mem_access #(
	parameter int DMEM_WORDS = 256
) (
	input  logic            clk,
	input  logic            exc_taken,
	exmem_if.consumer       stage,
	output core_pkg::xlen_t load_data,
	output logic            load_misaligned,
	output logic            store_misaligned
);
	import core_pkg::*;

	localparam int IDX_W = $clog2(DMEM_WORDS);

	xlen_t            dmem [DMEM_WORDS];
	logic [IDX_W-1:0] word_idx;
	logic [1:0]       byte_off;
	logic             misaligned;
	xlen_t            rword;
	logic [7:0]       ld_byte;
	logic [15:0]      ld_half;
	logic             ld_sign;
	logic [3:0]       byte_en;
	xlen_t            wdata;

	assign word_idx = stage.result[IDX_W+1:2]; // Wraps at DMEM_WORDS.
	assign byte_off = stage.result[1:0];

	always_comb begin
		case (stage.mem_flags.size)
			SIZE_BYTE: misaligned = 1'b0;
			SIZE_HALF: misaligned = byte_off[0];
			default:   misaligned = (byte_off != 2'b00);
		endcase
	end

	assign load_misaligned  = stage.mem_flags.read & misaligned;
	assign store_misaligned = stage.mem_flags.write & misaligned;

	// Load extraction.
	assign rword   = dmem[word_idx];
	assign ld_byte = rword[{byte_off, 3'b000} +: 8];
	assign ld_half = rword[{byte_off[1], 4'b0000} +: 16];

	always_comb begin
		case (stage.mem_flags.size)
			SIZE_BYTE: begin
				ld_sign   = ld_byte[7] & ~stage.mem_flags.zero_ext;
				load_data = {{24{ld_sign}}, ld_byte};
			end
			SIZE_HALF: begin
				ld_sign   = ld_half[15] & ~stage.mem_flags.zero_ext;
				load_data = {{16{ld_sign}}, ld_half};
			end
			default: begin
				ld_sign   = 1'b0;
				load_data = rword;
			end
		endcase
	end

	// Store lanes; data is replicated so each lane sees its byte.
	always_comb begin
		case (stage.mem_flags.size)
			SIZE_BYTE: begin
				byte_en = 4'b0001 << byte_off;
				wdata   = {4{stage.csr_data[7:0]}};
			end
			SIZE_HALF: begin
				byte_en = byte_off[1] ? 4'b1100 : 4'b0011;
				wdata   = {2{stage.csr_data[15:0]}};
			end
			default: begin
				byte_en = 4'b1111;
				wdata   = stage.csr_data;
			end
		endcase
	end

	// A misaligned store always raises exc_taken, so it never lands.
	always_ff @(posedge clk) begin
		if (stage.mem_flags.write && !exc_taken) begin
			for (int i = 0; i < 4; i++) begin
				if (byte_en[i])
					dmem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/mem_retire.sv
`timescale 1ns/10ps
`default_nettype none

module mem_retire (
	exmem_if.consumer            stage,
	input  core_pkg::xlen_t      load_data,
	input  core_pkg::xlen_t      csr_rdata,
	input  logic                 load_misaligned,
	input  logic                 store_misaligned,
	input  logic                 csr_illegal,
	output logic                 exc_taken,
	output core_pkg::exc_cause_t exc_cause,
	output core_pkg::xlen_t      exc_tval,
	output logic                 wb_we,
	output core_pkg::reg_addr_t  wb_waddr,
	output core_pkg::xlen_t      wb_data
);
	import core_pkg::*;

	logic [6:0] opcode;
	logic       is_jump;

	assign opcode  = stage.instruction[6:0];
	assign is_jump = (opcode == OPC_JAL) || (opcode == OPC_JALR);

	// Highest priority first.
	always_comb begin
		exc_taken = 1'b1;
		exc_cause = EXC_INSTR_MISALIGN;
		exc_tval  = '0;
		if (stage.exc_addr_if) begin
			exc_tval = is_jump ? stage.bad_jump_addr : stage.bad_branch_addr;
		end else if (csr_illegal) begin
			exc_cause = EXC_ILLEGAL;
			exc_tval  = stage.instruction;
		end else if (stage.break_op) begin
			exc_cause = EXC_BREAKPOINT;
		end else if (stage.syscall_op) begin
			exc_cause = EXC_ECALL;
		end else if (load_misaligned) begin
			exc_cause = EXC_LOAD_MISALIGN;
			exc_tval  = stage.result;
		end else if (store_misaligned) begin
			exc_cause = EXC_STORE_MISALIGN;
			exc_tval  = stage.result;
		end else begin
			exc_taken = 1'b0;
		end
	end

	assign wb_we    = stage.we & ~exc_taken;
	assign wb_waddr = stage.waddr;

	always_comb begin
		if (stage.mem_ex_sel)
			wb_data = load_data;
		else if (stage.csr_op != CSR_NONE)
			wb_data = csr_rdata; // Old CSR value.
		else
			wb_data = stage.result;
	end

endmodule

`default_nettype wire

// File: hw/mem_stage_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage_top #(
	parameter int DMEM_WORDS = 256
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 stall,
	input  logic                 flush,
	input  core_pkg::xlen_t      ex_pc,
	input  core_pkg::xlen_t      ex_instruction,
	input  core_pkg::xlen_t      ex_result,
	input  core_pkg::reg_addr_t  ex_waddr,
	input  logic                 ex_we,
	input  core_pkg::mem_flags_t ex_mem_flags,
	input  logic                 ex_mem_ex_sel,
	input  core_pkg::xlen_t      ex_bad_jump_addr,
	input  core_pkg::xlen_t      ex_bad_branch_addr,
	input  logic                 ex_break_op,
	input  logic                 ex_syscall_op,
	input  core_pkg::xlen_t      ex_csr_data,
	input  core_pkg::csr_op_t    ex_csr_op,
	input  logic                 ex_csr_imm_op,
	input  core_pkg::csr_addr_t  ex_csr_addr,
	input  logic                 ex_exc_addr_if,
	output logic                 wb_we,
	output core_pkg::reg_addr_t  wb_waddr,
	output core_pkg::xlen_t      wb_data,
	output logic                 exc_taken,
	output core_pkg::exc_cause_t exc_cause,
	output core_pkg::xlen_t      exc_pc
);
	import core_pkg::*;

	xlen_t load_data;
	logic  load_misaligned;
	logic  store_misaligned;
	xlen_t csr_rdata;
	logic  csr_illegal;
	xlen_t exc_tval;

	exmem_if i_exmem_if ();

	exmem_reg i_exmem_reg (
		.clk                (clk),
		.rst                (rst),
		.stall              (stall),
		.flush              (flush),
		.ex_pc              (ex_pc),
		.ex_instruction     (ex_instruction),
		.ex_result          (ex_result),
		.ex_waddr           (ex_waddr),
		.ex_we              (ex_we),
		.ex_mem_flags       (ex_mem_flags),
		.ex_mem_ex_sel      (ex_mem_ex_sel),
		.ex_bad_jump_addr   (ex_bad_jump_addr),
		.ex_bad_branch_addr (ex_bad_branch_addr),
		.ex_break_op        (ex_break_op),
		.ex_syscall_op      (ex_syscall_op),
		.ex_csr_data        (ex_csr_data),
		.ex_csr_op          (ex_csr_op),
		.ex_csr_imm_op      (ex_csr_imm_op),
		.ex_csr_addr        (ex_csr_addr),
		.ex_exc_addr_if     (ex_exc_addr_if),
		.out                (i_exmem_if.producer)
	);

	mem_access #(
		.DMEM_WORDS (DMEM_WORDS)
	) i_mem_access (
		.clk              (clk),
		.exc_taken        (exc_taken),
		.stage            (i_exmem_if.consumer),
		.load_data        (load_data),
		.load_misaligned  (load_misaligned),
		.store_misaligned (store_misaligned)
	);

	csr_file i_csr_file (
		.clk         (clk),
		.rst         (rst),
		.exc_taken   (exc_taken),
		.exc_cause   (exc_cause),
		.exc_tval    (exc_tval),
		.stage       (i_exmem_if.consumer),
		.csr_rdata   (csr_rdata),
		.csr_illegal (csr_illegal)
	);

	// Exception outcome gates the store and CSR commits.
	mem_retire i_mem_retire (
		.stage            (i_exmem_if.consumer),
		.load_data        (load_data),
		.csr_rdata        (csr_rdata),
		.load_misaligned  (load_misaligned),
		.store_misaligned (store_misaligned),
		.csr_illegal      (csr_illegal),
		.exc_taken        (exc_taken),
		.exc_cause        (exc_cause),
		.exc_tval         (exc_tval),
		.wb_we            (wb_we),
		.wb_waddr         (wb_waddr),
		.wb_data          (wb_data)
	);

	assign exc_pc = i_exmem_if.pc;

endmodule

`default_nettype wire

// File: list.f
hw/core_pkg.sv
hw/exmem_if.sv
hw/exmem_reg.sv
hw/mem_access.sv
hw/csr_file.sv
hw/mem_retire.sv
hw/mem_stage_top.sv
tests/mem_stage_checker.sv
tests/tb_mem_stage.sv

// File: tests/mem_stage_checker.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage_checker #(
	parameter int DMEM_WORDS = 256
) (
	input  logic                 clk, rst, stall, flush,
	input  core_pkg::xlen_t      ex_pc, ex_instruction, ex_result,
	input  core_pkg::reg_addr_t  ex_waddr,
	input  logic                 ex_we,
	input  core_pkg::mem_flags_t ex_mem_flags,
	input  logic                 ex_mem_ex_sel,
	input  core_pkg::xlen_t      ex_bad_jump_addr, ex_bad_branch_addr,
	input  logic                 ex_break_op, ex_syscall_op,
	input  core_pkg::xlen_t      ex_csr_data,
	input  core_pkg::csr_op_t    ex_csr_op,
	input  logic                 ex_csr_imm_op,
	input  core_pkg::csr_addr_t  ex_csr_addr,
	input  logic                 ex_exc_addr_if,
	input  logic                 wb_we,
	input  core_pkg::reg_addr_t  wb_waddr,
	input  core_pkg::xlen_t      wb_data,
	input  logic                 exc_taken,
	input  core_pkg::exc_cause_t exc_cause,
	input  core_pkg::xlen_t      exc_pc,
	input  logic                 done,
	output logic                 reported,
	output int                   fail_count
);
	import core_pkg::*;

	localparam int IDX_W     = $clog2(DMEM_WORDS);
	localparam int NUM_TESTS = 7;

	typedef struct packed {
		xlen_t      pc;
		xlen_t      instr;
		xlen_t      result;
		reg_addr_t  waddr;
		logic       we;
		mem_flags_t flags;
		logic       mem_ex_sel;
		xlen_t      bja;
		xlen_t      bba;
		logic       brk;
		logic       sys;
		xlen_t      csr_data;
		csr_op_t    csr_op;
		logic       imm;
		csr_addr_t  csr_addr;
		logic       eai;
	} stage_t;

	stage_t           m = '0; // Model of the EX/MEM register.
	xlen_t            mem [DMEM_WORDS];
	xlen_t            m_mscratch, m_mepc, m_mcause, m_mtval;
	logic [IDX_W-1:0] widx;
	logic [1:0]       off;
	xlen_t            nv;
	xlen_t            e_load, e_rdata, e_tval, e_wb_data;
	logic             e_writes, e_illegal, e_taken, e_wb_we;
	exc_cause_t       e_cause;
	logic             armed = 1'b0;
	logic             last_ctl = 1'b0; // Last edge saw rst, flush or stall.
	logic [2:0]       cat;
	logic [2:0]       t;
	int               checks [NUM_TESTS] = '{default: 0};
	int               fails [NUM_TESTS] = '{default: 0};
	int               total = 0;
	int               errors = 0;
	int               starved = 0;
	logic             report_done = 1'b0;
	string            names [NUM_TESTS] = '{"reset_flush_stall", "load_store", "csr_ops",
		"csr_illegal", "exc_priority", "trap_record", "alu_writeback"};

	assign reported   = report_done;
	assign fail_count = errors + starved;

	task automatic raise_exc(input exc_cause_t cause, input xlen_t tval);
		e_taken = 1'b1;
		e_cause = cause;
		e_tval  = tval;
	endtask

	// Expected outputs for the instruction now held in the model register.
	task automatic predict();
		xlen_t       w;
		logic [7:0]  b;
		logic [15:0] h;
		logic        mis;
		logic        known;
		logic        is_jump;
		widx = IDX_W'((m.result >> 2) % DMEM_WORDS);
		off  = m.result[1:0];
		w    = mem[widx];
		b    = w[8*off +: 8];
		h    = w[16*off[1] +: 16];
		mis  = (m.flags.size == SIZE_HALF && off[0]) ||
			(m.flags.size == SIZE_WORD && off != 2'd0);
		case (m.flags.size)
			SIZE_BYTE: e_load = m.flags.zero_ext ? {24'd0, b} : {{24{b[7]}}, b};
			SIZE_HALF: e_load = m.flags.zero_ext ? {16'd0, h} : {{16{h[15]}}, h};
			default:   e_load = w;
		endcase
		known = 1'b1;
		case (m.csr_addr)
			CSR_MSCRATCH: e_rdata = m_mscratch;
			CSR_MEPC:     e_rdata = m_mepc;
			CSR_MCAUSE:   e_rdata = m_mcause;
			CSR_MTVAL:    e_rdata = m_mtval;
			CSR_MHARTID:  e_rdata = '0;
			default: begin
				e_rdata = '0;
				known   = 1'b0;
			end
		endcase
		e_writes  = !(m.imm && m.csr_data == '0 && (m.csr_op == CSR_RS || m.csr_op == CSR_RC));
		e_illegal = m.csr_op != CSR_NONE &&
			(!known || (m.csr_addr == CSR_MHARTID && e_writes));
		// Lowest priority first so that higher causes override.
		e_taken = 1'b0;
		e_cause = EXC_INSTR_MISALIGN;
		e_tval  = '0;
		if (m.flags.write && mis)
			raise_exc(EXC_STORE_MISALIGN, m.result);
		if (m.flags.read && mis)
			raise_exc(EXC_LOAD_MISALIGN, m.result);
		if (m.sys)
			raise_exc(EXC_ECALL, '0);
		if (m.brk)
			raise_exc(EXC_BREAKPOINT, '0);
		if (e_illegal)
			raise_exc(EXC_ILLEGAL, m.instr);
		is_jump = m.instr[6:0] inside {OPC_JAL, OPC_JALR};
		if (m.eai)
			raise_exc(EXC_INSTR_MISALIGN, is_jump ? m.bja : m.bba);
		e_wb_we = m.we && !e_taken;
		if (m.mem_ex_sel)
			e_wb_data = e_load;
		else if (m.csr_op != CSR_NONE)
			e_wb_data = e_rdata;
		else
			e_wb_data = m.result;
	endtask

	always @(posedge clk) begin
		if (rst) begin
			m_mscratch = '0;
			m_mepc     = '0;
			m_mcause   = '0;
			m_mtval    = '0;
			m          = '0;
			armed      = 1'b1;
		end else begin
			if (e_taken) begin
				m_mepc   = m.pc;
				m_mcause = {27'd0, e_cause};
				m_mtval  = e_tval;
			end else begin
				if (m.flags.write) begin
					case (m.flags.size)
						SIZE_BYTE: mem[widx][8*off +: 8] = m.csr_data[7:0];
						SIZE_HALF: mem[widx][16*off[1] +: 16] = m.csr_data[15:0];
						default:   mem[widx] = m.csr_data;
					endcase
				end
				if (m.csr_op != CSR_NONE && e_writes) begin
					case (m.csr_op)
						CSR_RW:  nv = m.csr_data;
						CSR_RS:  nv = e_rdata | m.csr_data;
						CSR_RC:  nv = e_rdata & ~m.csr_data;
						default: nv = e_rdata;
					endcase
					case (m.csr_addr)
						CSR_MSCRATCH: m_mscratch = nv;
						CSR_MEPC:     m_mepc = nv;
						CSR_MCAUSE:   m_mcause = nv;
						CSR_MTVAL:    m_mtval = nv;
						default:      ;
					endcase
				end
			end
			if (flush)
				m = '0;
			else if (!stall)
				m = '{pc: ex_pc, instr: ex_instruction, result: ex_result, waddr: ex_waddr,
					we: ex_we, flags: ex_mem_flags, mem_ex_sel: ex_mem_ex_sel,
					bja: ex_bad_jump_addr, bba: ex_bad_branch_addr, brk: ex_break_op,
					sys: ex_syscall_op, csr_data: ex_csr_data, csr_op: ex_csr_op,
					imm: ex_csr_imm_op, csr_addr: ex_csr_addr, eai: ex_exc_addr_if};
		end
		last_ctl = rst || flush || stall;
		predict();
	end

	// Outputs are settled by the falling edge.
	always @(negedge clk) begin
		if (armed) begin
			if (last_ctl)
				cat = 3'd0;
			else if (e_taken)
				cat = (e_cause == EXC_ILLEGAL) ? 3'd3 : 3'd4;
			else if (m.csr_op != CSR_NONE)
				cat = (m.csr_addr inside {CSR_MEPC, CSR_MCAUSE, CSR_MTVAL}) ? 3'd5 : 3'd2;
			else if (m.flags.read || m.flags.write)
				cat = 3'd1;
			else
				cat = 3'd6;
			checks[cat]++;
			total++;
			if (wb_we !== e_wb_we || wb_waddr !== m.waddr || wb_data !== e_wb_data ||
				exc_taken !== e_taken || exc_pc !== m.pc ||
				(e_taken && exc_cause !== e_cause)) begin
				fails[cat]++;
				errors++;
				$display("Error at %0t ns: %s got %b %0d %h %b %0d %h, want %b %0d %h %b %0d %h",
					$time, names[cat], wb_we, wb_waddr, wb_data, exc_taken, exc_cause, exc_pc,
					e_wb_we, m.waddr, e_wb_data, e_taken, e_cause, m.pc);
			end
		end
	end

	always @(posedge done) begin
		t = '0;
		repeat (NUM_TESTS) begin
			if (checks[t] == 0) begin
				starved++;
				$display("Test %s was never exercised by the random sequence", names[t]);
			end else begin
				$display("Test %s: %0d checks, %0d mismatches", names[t], checks[t], fails[t]);
			end
			t++;
		end
		$display("Summary: %0d checks, %0d mismatches, %0d tests not exercised",
			total, errors, starved);
		report_done = 1'b1;
	end

endmodule

`default_nettype wire

// File: tests/tb_mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_stage;
	import core_pkg::*;

	localparam int DMEM_WORDS   = 256;
	localparam int HALF_PERIOD  = 20;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 8;
	localparam int INIT_WORDS   = 16; // Words that random loads and stores may touch.
	localparam int NUM_CYCLES   = 3000;
	localparam int WATCHDOG_NS  = (RESET_CYCLES + INIT_WORDS + NUM_CYCLES + 4) * 40 + 400;

	logic       clk;
	logic       rst;
	logic       stall;
	logic       flush;
	xlen_t      ex_pc;
	xlen_t      ex_instruction;
	xlen_t      ex_result;
	reg_addr_t  ex_waddr;
	logic       ex_we;
	mem_flags_t ex_mem_flags;
	logic       ex_mem_ex_sel;
	xlen_t      ex_bad_jump_addr;
	xlen_t      ex_bad_branch_addr;
	logic       ex_break_op;
	logic       ex_syscall_op;
	xlen_t      ex_csr_data;
	csr_op_t    ex_csr_op;
	logic       ex_csr_imm_op;
	csr_addr_t  ex_csr_addr;
	logic       ex_exc_addr_if;
	logic       wb_we;
	reg_addr_t  wb_waddr;
	xlen_t      wb_data;
	logic       exc_taken;
	exc_cause_t exc_cause;
	xlen_t      exc_pc;
	logic       done;
	logic       reported;
	int         fail_count;
	integer     seed = 14;

	mem_stage_top #(.DMEM_WORDS(DMEM_WORDS)) i_mem_stage_top (.*);

	mem_stage_checker #(.DMEM_WORDS(DMEM_WORDS)) i_mem_stage_checker (.*);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		#WATCHDOG_NS;
		$display("Watchdog timeout: the test sequence did not reach its end");
		$display("SOME TESTS FAILED");
		$finish;
	end

	task automatic clear_inputs();
		stall              = 1'b0;
		flush              = 1'b0;
		ex_pc              = '0;
		ex_instruction     = '0;
		ex_result          = '0;
		ex_waddr           = '0;
		ex_we              = 1'b0;
		ex_mem_flags       = '0;
		ex_mem_ex_sel      = 1'b0;
		ex_bad_jump_addr   = '0;
		ex_bad_branch_addr = '0;
		ex_break_op        = 1'b0;
		ex_syscall_op      = 1'b0;
		ex_csr_data        = '0;
		ex_csr_op          = CSR_NONE;
		ex_csr_imm_op      = 1'b0;
		ex_csr_addr        = '0;
		ex_exc_addr_if     = 1'b0;
	endtask

	// One random instruction class per cycle, fields kept coherent.
	task automatic drive_random();
		logic [31:0] r;
		logic [31:0] extra;
		int          cls;
		clear_inputs();
		r                  = $random(seed);
		extra              = $random(seed);
		cls                = r % 10;
		ex_pc              = $random(seed);
		ex_pc[1:0]         = 2'b00;
		ex_instruction     = $random(seed);
		ex_result          = $random(seed);
		ex_waddr           = r[12:8];
		ex_bad_jump_addr   = $random(seed);
		ex_bad_branch_addr = $random(seed);
		case (cls)
			0: begin
				ex_we               = 1'b1;
				ex_instruction[6:0] = 7'h33;
			end
			1, 2: begin
				ex_result = ex_result & 32'hFFFF_FC3F; // Aliases above bit 9.
				if (r[19])
					ex_result[1:0] = 2'b00;
				ex_mem_flags.size = (r[17:16] == 2'd3) ? SIZE_WORD : r[17:16];
				if (cls == 1) begin
					ex_we                  = 1'b1;
					ex_mem_ex_sel          = 1'b1;
					ex_mem_flags.read      = 1'b1;
					ex_mem_flags.zero_ext  = r[18];
					ex_instruction[6:0]    = 7'h03;
				end else begin
					ex_mem_flags.write  = 1'b1;
					ex_csr_data         = $random(seed); // Store data.
					ex_instruction[6:0] = 7'h23;
				end
			end
			3, 4: begin
				ex_we               = 1'b1;
				ex_instruction[6:0] = 7'h73;
				case (r[21:20])
					2'd2:    ex_csr_op = CSR_RS;
					2'd3:    ex_csr_op = CSR_RC;
					default: ex_csr_op = CSR_RW;
				endcase
				case (r[24:22])
					3'd1:    ex_csr_addr = CSR_MEPC;
					3'd2:    ex_csr_addr = CSR_MCAUSE;
					3'd3:    ex_csr_addr = CSR_MTVAL;
					3'd4:    ex_csr_addr = CSR_MHARTID;
					3'd5:    ex_csr_addr = extra[31:20];
					default: ex_csr_addr = CSR_MSCRATCH;
				endcase
				ex_csr_imm_op = r[25];
				ex_csr_data   = $random(seed);
				if (r[25])
					ex_csr_data[31:5] = '0; // 5-bit immediate.
				if (r[27:26] == 2'd0)
					ex_csr_data = '0;
			end
			5: begin
				ex_break_op    = 1'b1;
				ex_instruction = 32'h0010_0073;
			end
			6: begin
				ex_syscall_op  = 1'b1;
				ex_instruction = 32'h0000_0073;
			end
			7: begin
				ex_exc_addr_if      = 1'b1;
				ex_we               = r[20];
				ex_instruction[6:0] = r[21] ? OPC_JAL : OPC_JALR;
			end
			8: begin
				ex_exc_addr_if      = 1'b1;
				ex_instruction[6:0] = 7'h63;
			end
			default: clear_inputs(); // Bubble.
		endcase
		// Stack extra causes on top to exercise priority.
		if (cls != 9) begin
			if (extra[2:0] == 3'd0)
				ex_break_op = 1'b1;
			if (extra[5:3] == 3'd0)
				ex_syscall_op = 1'b1;
			if (extra[9:6] == 4'd0)
				ex_exc_addr_if = 1'b1;
		end
		stall = (extra[12:10] == 3'd0);
		flush = (extra[16:13] == 4'd0);
	endtask

	initial begin
		clear_inputs();
		rst  = 1'b1;
		done = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		for (int i = 0; i < INIT_WORDS; i++) begin
			clear_inputs();
			ex_mem_flags.write = 1'b1;
			ex_mem_flags.size  = SIZE_WORD;
			ex_result          = i * 4;
			ex_csr_data        = $random(seed);
			ex_instruction     = 32'h0000_2023;
			@(posedge clk);
			#DRIVE_DELAY;
		end
		repeat (NUM_CYCLES) begin
			drive_random();
			@(posedge clk);
			#DRIVE_DELAY;
		end
		clear_inputs();
		repeat (2) @(posedge clk);
		done = 1'b1;
		wait (reported);
		if (fail_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
